// ==== Makefile ====
SIM := obj_dir/Vdeconv_core_tb

.PHONY: run clean

run: $(SIM)
	@./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi; exit $$status

$(SIM): build.f $(wildcard hdl/*.sv tb/*.sv)
	verilator --binary --timing --assert --top-module deconv_core_tb \
		-f build.f -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
hdl/deconv_pkg.sv
hdl/input_sequencer.sv
hdl/deconv_lane.sv
hdl/result_drain.sv
hdl/deconv_core.sv
tb/clock_gen.sv
tb/deconv_core_tb.sv

// ==== hdl/deconv_core.sv ====
`timescale 1ns/1ns

module deconv_core (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_wgt_valid,
    input  deconv_pkg::wgt_beat_t  i_wgt,
    input  logic                   i_feat_valid,
    input  deconv_pkg::feat_beat_t i_feat,
    output logic                   o_res_valid,
    output deconv_pkg::res_beat_t  o_res
);
    import deconv_pkg::*;

    wgt_wr_t          wgt_wr;
    issue_t           issue;
    logic             rd_en;
    logic [POS_W-1:0] rd_pos;
    res_beat_t        lane_data;

    input_sequencer u_input_sequencer (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_wgt_valid  (i_wgt_valid),
        .i_feat_valid (i_feat_valid),
        .i_feat       (i_feat),
        .o_wgt_wr     (wgt_wr),
        .o_issue      (issue)
    );

    //////////////////////////////////////////////////////////////////////
    // One lane per kernel on its own weight slice
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < NUM_KERNELS; k++)
    begin : g_lane
        deconv_lane u_deconv_lane (
            .i_clk      (i_clk),
            .i_rst      (i_rst),
            .i_wgt_wr   (wgt_wr),
            .i_wgt_data (i_wgt[k]),
            .i_issue    (issue),
            .i_rd_en    (rd_en),
            .i_rd_pos   (rd_pos),
            .o_rd_data  (lane_data[k])
        );
    end

    result_drain u_result_drain (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_issue     (issue),
        .i_lane_data (lane_data),
        .o_rd_en     (rd_en),
        .o_rd_pos    (rd_pos),
        .o_res_valid (o_res_valid),
        .o_res       (o_res)
    );

endmodule

// ==== hdl/deconv_lane.sv ====
`timescale 1ns/1ns

module deconv_lane (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  deconv_pkg::wgt_wr_t          i_wgt_wr,
    input  deconv_pkg::pix_t             i_wgt_data,
    input  deconv_pkg::issue_t           i_issue,
    input  logic                         i_rd_en,
    input  logic [deconv_pkg::POS_W-1:0] i_rd_pos,
    output deconv_pkg::acc_t             o_rd_data
);
    import deconv_pkg::*;

    pix_t             wgt_mem [NUM_CHANNELS][NUM_TAPS];
    acc_t             acc [NUM_POS];
    acc_t             tap_prod [NUM_TAPS];
    logic [POS_W-1:0] tap_pos [NUM_TAPS];

    // Add with the halving rule on carry out
    function automatic acc_t ovf_add(input acc_t a, input acc_t b);
        logic [ACC_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum[ACC_W])
        begin
            return sum[ACC_W:1];
        end
        return sum[ACC_W-1:0];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Weight store
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_wgt_wr.en)
        begin
            wgt_mem[i_wgt_wr.chan][i_wgt_wr.tap] <= i_wgt_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Nine taps per issued pixel
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int t = 0; t < NUM_TAPS; t++)
        begin
            tap_prod[t] = ACC_W'(i_issue.pixel) * ACC_W'(wgt_mem[i_issue.chan][t]);
            // Tap (wr, wc) lands at (row + wr, col + wc)
            tap_pos[t]  = POS_W'((int'(i_issue.row) + t / WGT_SIZE) * OUT_SIZE
                                 + int'(i_issue.col) + t % WGT_SIZE);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            for (int p = 0; p < NUM_POS; p++)
            begin
                acc[p] <= '0;
            end
        end
        else
        begin
            if (i_issue.valid)
            begin
                for (int t = 0; t < NUM_TAPS; t++)
                begin
                    acc[tap_pos[t]] <= ovf_add(acc[tap_pos[t]], tap_prod[t]);
                end
            end
            // Cleared as it is read so the next image starts from zero
            if (i_rd_en)
            begin
                acc[i_rd_pos] <= '0;
            end
        end
    end

    assign o_rd_data = acc[i_rd_pos];

endmodule

// ==== hdl/deconv_pkg.sv ====
package deconv_pkg;

    //////////////////////////////////////////////////////////////////////
    // Geometry
    //////////////////////////////////////////////////////////////////////

    localparam int FEAT_SIZE    = 4;
    localparam int WGT_SIZE     = 3;
    localparam int OUT_SIZE     = FEAT_SIZE + WGT_SIZE - 1;
    localparam int NUM_KERNELS  = 4;
    localparam int NUM_CHANNELS = 4;
    localparam int PIX_W        = 16;
    localparam int ACC_W        = 32;

    // Channel ends must be at least one channel walk apart
    localparam int ISSUE_GAP    = FEAT_SIZE * FEAT_SIZE;

    localparam int NUM_TAPS     = WGT_SIZE * WGT_SIZE;
    localparam int NUM_POS      = OUT_SIZE * OUT_SIZE;
    localparam int TAP_W        = $clog2(NUM_TAPS);
    localparam int POS_W        = $clog2(NUM_POS);
    localparam int CHAN_W       = $clog2(NUM_CHANNELS);
    localparam int COORD_W      = $clog2(FEAT_SIZE);

    //////////////////////////////////////////////////////////////////////
    // Beat and command types
    //////////////////////////////////////////////////////////////////////

    typedef logic [PIX_W-1:0] pix_t;
    typedef logic [ACC_W-1:0] acc_t;

    // Kernel 0 in the low slice
    typedef pix_t [NUM_KERNELS-1:0] wgt_beat_t;

    // One pixel per 2x2 quadrant with top-left lowest
    typedef struct packed {
        pix_t br;
        pix_t bl;
        pix_t tr;
        pix_t tl;
    } feat_beat_t;

    typedef struct packed {
        logic              en;
        logic [CHAN_W-1:0] chan;
        logic [TAP_W-1:0]  tap;
    } wgt_wr_t;

    typedef struct packed {
        logic               valid;
        pix_t               pixel;
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
        logic [CHAN_W-1:0]  chan;
        logic               last;
    } issue_t;

    typedef acc_t [NUM_KERNELS-1:0] res_beat_t;

endpackage

// ==== hdl/input_sequencer.sv ====
`timescale 1ns/1ns

module input_sequencer (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_wgt_valid,
    input  logic                   i_feat_valid,
    input  deconv_pkg::feat_beat_t i_feat,
    output deconv_pkg::wgt_wr_t    o_wgt_wr,
    output deconv_pkg::issue_t     o_issue
);
    import deconv_pkg::*;

    localparam int HALF      = FEAT_SIZE / 2;
    localparam int BEATS     = HALF * HALF;
    localparam int BEAT_W    = $clog2(BEATS);
    localparam int PIX_IDX_W = $clog2(ISSUE_GAP);

    logic [TAP_W-1:0]     wgt_tap;
    logic [CHAN_W-1:0]    wgt_chan;

    pix_t                 asm_buf [FEAT_SIZE][FEAT_SIZE];
    logic [BEAT_W-1:0]    feat_cnt;
    logic [CHAN_W-1:0]    feat_chan;
    logic [COORD_W-1:0]   row_off;
    logic [COORD_W-1:0]   col_off;
    logic                 feat_last;
    logic                 chan_done;
    logic [CHAN_W-1:0]    done_chan;

    pix_t                 issue_buf [FEAT_SIZE][FEAT_SIZE];
    logic                 issue_busy;
    logic [CHAN_W-1:0]    issue_chan;
    logic [PIX_IDX_W-1:0] pix_idx;
    logic [COORD_W-1:0]   issue_row;
    logic [COORD_W-1:0]   issue_col;
    logic                 issue_end;
    logic                 img_active;

    //////////////////////////////////////////////////////////////////////
    // Weight beats
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            wgt_tap  <= '0;
            wgt_chan <= '0;
        end
        else if (i_wgt_valid)
        begin
            if (wgt_tap == TAP_W'(NUM_TAPS - 1))
            begin
                wgt_tap  <= '0;
                wgt_chan <= wgt_chan + 1'b1;
            end
            else
            begin
                wgt_tap <= wgt_tap + 1'b1;
            end
        end
    end

    assign o_wgt_wr = '{en: i_wgt_valid, chan: wgt_chan, tap: wgt_tap};

    //////////////////////////////////////////////////////////////////////
    // Feature assembly
    //////////////////////////////////////////////////////////////////////

    // Beat k sits at row k mod 2, column k div 2 of every quadrant
    assign row_off   = COORD_W'(feat_cnt % HALF);
    assign col_off   = COORD_W'(feat_cnt / HALF);
    assign feat_last = i_feat_valid && (feat_cnt == BEAT_W'(BEATS - 1));

    always_ff @(posedge i_clk)
    begin
        if (i_feat_valid)
        begin
            asm_buf[row_off][col_off]               <= i_feat.tl;
            asm_buf[row_off][col_off + HALF]        <= i_feat.tr;
            asm_buf[row_off + HALF][col_off]        <= i_feat.bl;
            asm_buf[row_off + HALF][col_off + HALF] <= i_feat.br;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            feat_cnt  <= '0;
            feat_chan <= '0;
            chan_done <= 1'b0;
            done_chan <= '0;
        end
        else
        begin
            chan_done <= feat_last;
            if (i_feat_valid)
            begin
                feat_cnt <= feat_cnt + 1'b1;
            end
            if (feat_last)
            begin
                feat_chan <= feat_chan + 1'b1;
                done_chan <= feat_chan;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pixel issue
    //////////////////////////////////////////////////////////////////////

    assign issue_end = issue_busy && (pix_idx == PIX_IDX_W'(ISSUE_GAP - 1));
    assign issue_row = pix_idx[PIX_IDX_W-1 -: COORD_W];
    assign issue_col = pix_idx[COORD_W-1:0];

    always_ff @(posedge i_clk)
    begin
        if (chan_done)
        begin
            issue_buf <= asm_buf;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            issue_busy <= 1'b0;
            issue_chan <= '0;
            pix_idx    <= '0;
        end
        else if (chan_done)
        begin
            issue_busy <= 1'b1;
            issue_chan <= done_chan;
            pix_idx    <= '0;
        end
        else if (issue_end)
        begin
            issue_busy <= 1'b0;
        end
        else if (issue_busy)
        begin
            pix_idx <= pix_idx + 1'b1;
        end
    end

    always_comb
    begin
        o_issue.valid = issue_busy;
        o_issue.pixel = issue_buf[issue_row][issue_col];
        o_issue.row   = issue_row;
        o_issue.col   = issue_col;
        o_issue.chan  = issue_chan;
        o_issue.last  = issue_end && (issue_chan == CHAN_W'(NUM_CHANNELS - 1));
    end

    // Image runs from its first feature beat to its last issued pixel
    assign img_active = (feat_cnt != '0) || (feat_chan != '0) || chan_done || issue_busy;

    assert property (@(posedge i_clk) disable iff (i_rst)
        feat_last |=> (!issue_busy || issue_end))
        else $error("feature channel completed while issue still busy");

    assert property (@(posedge i_clk) disable iff (i_rst)
        i_wgt_valid |-> !img_active)
        else $error("weight beat during an image");

endmodule

// ==== hdl/result_drain.sv ====
`timescale 1ns/1ns

module result_drain (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  deconv_pkg::issue_t           i_issue,
    input  deconv_pkg::res_beat_t        i_lane_data,
    output logic                         o_rd_en,
    output logic [deconv_pkg::POS_W-1:0] o_rd_pos,
    output logic                         o_res_valid,
    output deconv_pkg::res_beat_t        o_res
);
    import deconv_pkg::*;

    logic             rd_busy;
    logic [POS_W-1:0] rd_cnt;
    logic             img_end;
    logic             rd_last;

    assign img_end = i_issue.valid && i_issue.last;
    assign rd_last = rd_busy && (rd_cnt == POS_W'(NUM_POS - 1));

    //////////////////////////////////////////////////////////////////////
    // Read sequence over all output positions
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            rd_busy <= 1'b0;
            rd_cnt  <= '0;
        end
        else if (img_end)
        begin
            rd_busy <= 1'b1;
            rd_cnt  <= '0;
        end
        else if (rd_last)
        begin
            rd_busy <= 1'b0;
            rd_cnt  <= '0;
        end
        else if (rd_busy)
        begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

    assign o_rd_en  = rd_busy;
    assign o_rd_pos = rd_cnt;

    // Output beat lags its read by one cycle
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_res_valid <= 1'b0;
        end
        else
        begin
            o_res_valid <= rd_busy;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (rd_busy)
        begin
            o_res <= i_lane_data;
        end
    end

    assert property (@(posedge i_clk) disable iff (i_rst)
        img_end |-> !rd_busy)
        else $error("image ended while previous drain still running");

endmodule

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen (
    output logic o_clk,
    output logic o_rst
);
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 3;

    initial
    begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial
    begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// ==== tb/deconv_core_tb.sv ====
`timescale 1ns/1ns

module deconv_core_tb;
    import deconv_pkg::*;

    localparam int HALF            = FEAT_SIZE / 2;
    localparam int FEAT_BEATS      = HALF * HALF;
    localparam int RES_LATENCY     = 18;
    localparam int LOAD_CYCLES     = NUM_CHANNELS * NUM_TAPS + 2;
    localparam int IMAGE_CYCLES    = NUM_CHANNELS * ISSUE_GAP + RES_LATENCY + NUM_POS + 4;
    // Five weight loads and six images in all
    localparam int WATCHDOG_CYCLES = 2 * (16 + 5 * LOAD_CYCLES + 6 * IMAGE_CYCLES);

    logic       clk;
    logic       rst;
    logic       wgt_valid;
    wgt_beat_t  wgt;
    logic       feat_valid;
    feat_beat_t feat;
    logic       res_valid;
    res_beat_t  res;

    int   seed = 32'hfd45;
    pix_t wgt_tab [NUM_KERNELS][NUM_CHANNELS][NUM_TAPS];
    pix_t feat_tab [NUM_CHANNELS][FEAT_SIZE][FEAT_SIZE];
    acc_t exp_tab [NUM_KERNELS][NUM_POS];

    clock_gen u_clock_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    deconv_core deconv_core_i (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_wgt_valid  (wgt_valid),
        .i_wgt        (wgt),
        .i_feat_valid (feat_valid),
        .i_feat       (feat),
        .o_res_valid  (res_valid),
        .o_res        (res)
    );

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_res(input int pos, input res_beat_t got, input res_beat_t want);
        for (int k = 0; k < NUM_KERNELS; k++)
        begin
            if (got[k] !== want[k])
            begin
                $display("ERR o_res kernel %0d pos %0d: got %h expected %h",
                         k, pos, got[k], want[k]);
                abort_run();
            end
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        if (got != want)
        begin
            $display("ERR %s: got %h expected %h", name, got, want);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Sums of 2^32 or more are kept halved
    function automatic acc_t model_add(input acc_t acc, input acc_t prod);
        logic [63:0] sum;
        sum = {32'd0, acc} + {32'd0, prod};
        if (sum >= 64'h1_0000_0000)
        begin
            sum = sum >> 1;
        end
        return sum[31:0];
    endfunction

    // Accumulation order follows the hardware (channel, row-major pixel, tap)
    task automatic build_expected();
        acc_t prod;
        int   pos;
        exp_tab = '{default: '0};
        for (int k = 0; k < NUM_KERNELS; k++)
        begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++)
            begin
                for (int p = 0; p < FEAT_SIZE * FEAT_SIZE; p++)
                begin
                    for (int t = 0; t < NUM_TAPS; t++)
                    begin
                        pos  = (p / FEAT_SIZE + t / WGT_SIZE) * OUT_SIZE
                               + p % FEAT_SIZE + t % WGT_SIZE;
                        prod = {16'd0, feat_tab[ch][p / FEAT_SIZE][p % FEAT_SIZE]}
                               * {16'd0, wgt_tab[k][ch][t]};
                        exp_tab[k][pos] = model_add(exp_tab[k][pos], prod);
                    end
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic fill_weights(input bit rnd, input pix_t value);
        for (int k = 0; k < NUM_KERNELS; k++)
        begin
            for (int i = 0; i < NUM_CHANNELS * NUM_TAPS; i++)
            begin
                wgt_tab[k][i / NUM_TAPS][i % NUM_TAPS] = rnd ? pix_t'($random(seed)) : value;
            end
        end
    endtask

    task automatic fill_features(input bit rnd, input pix_t value);
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
        begin
            for (int p = 0; p < FEAT_SIZE * FEAT_SIZE; p++)
            begin
                feat_tab[ch][p / FEAT_SIZE][p % FEAT_SIZE] = rnd ? pix_t'($random(seed)) : value;
            end
        end
    endtask

    task automatic load_weights();
        wgt_beat_t beat;
        for (int i = 0; i < NUM_CHANNELS * NUM_TAPS; i++)
        begin
            for (int k = 0; k < NUM_KERNELS; k++)
            begin
                beat[k] = wgt_tab[k][i / NUM_TAPS][i % NUM_TAPS];
            end
            @(posedge clk);
            wgt_valid <= 1'b1;
            wgt       <= beat;
        end
        @(posedge clk);
        wgt_valid <= 1'b0;
    endtask

    // Channel ends land exactly ISSUE_GAP cycles apart
    task automatic send_image();
        feat_beat_t beat;
        int         ro;
        int         co;
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
        begin
            for (int b = 0; b < FEAT_BEATS; b++)
            begin
                ro      = b % HALF;
                co      = b / HALF;
                beat.tl = feat_tab[ch][ro][co];
                beat.tr = feat_tab[ch][ro][co + HALF];
                beat.bl = feat_tab[ch][ro + HALF][co];
                beat.br = feat_tab[ch][ro + HALF][co + HALF];
                @(posedge clk);
                feat_valid <= 1'b1;
                feat       <= beat;
            end
            @(posedge clk);
            feat_valid <= 1'b0;
            if (ch != NUM_CHANNELS - 1)
            begin
                repeat (ISSUE_GAP - FEAT_BEATS - 1) @(posedge clk);
            end
        end
    endtask

    // Entered on the edge that accepted the last feature beat
    task automatic collect_results();
        res_beat_t want;
        int        lat;
        int        n;
        lat = 0;
        n   = 0;
        // Each later negedge follows one more rising edge
        @(negedge clk);
        while (res_valid !== 1'b1 && lat < 4 * RES_LATENCY)
        begin
            @(negedge clk);
            lat++;
        end
        check_count("o_res_valid latency", lat, RES_LATENCY);
        while (res_valid === 1'b1 && n < NUM_POS)
        begin
            for (int k = 0; k < NUM_KERNELS; k++)
            begin
                want[k] = exp_tab[k][n];
            end
            check_res(n, res, want);
            n++;
            @(negedge clk);
        end
        check_count("o_res_valid beats", n, NUM_POS);
        check_count("o_res_valid after last beat", int'(res_valid), 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        int n;
        n = 0;
        repeat (8)
        begin
            @(negedge clk);
            if (res_valid !== 1'b0)
            begin
                n++;
            end
        end
        check_count("o_res_valid after reset", n, 0);
    endtask

    // Each output is channels times rows overlapped times columns overlapped
    task automatic test_uniform();
        int ovl [OUT_SIZE];
        fill_weights(1'b0, 16'd1);
        fill_features(1'b0, 16'd1);
        for (int x = 0; x < OUT_SIZE; x++)
        begin
            ovl[x] = 0;
            for (int wr = 0; wr < WGT_SIZE; wr++)
            begin
                if (x - wr >= 0 && x - wr < FEAT_SIZE)
                begin
                    ovl[x]++;
                end
            end
        end
        for (int k = 0; k < NUM_KERNELS; k++)
        begin
            for (int p = 0; p < NUM_POS; p++)
            begin
                exp_tab[k][p] = acc_t'(NUM_CHANNELS * ovl[p / OUT_SIZE] * ovl[p % OUT_SIZE]);
            end
        end
        load_weights();
        send_image();
        collect_results();
    endtask

    task automatic test_data(input bit rnd, input pix_t value);
        fill_weights(rnd, value);
        fill_features(rnd, value);
        build_expected();
        load_weights();
        send_image();
        collect_results();
    endtask

    task automatic test_back_to_back();
        test_data(1'b1, 16'd0);
        // Zero image with the weights kept must come out clean
        fill_features(1'b0, 16'd0);
        exp_tab = '{default: '0};
        send_image();
        collect_results();
        test_data(1'b1, 16'd0);
    endtask

    initial
    begin
        wgt_valid  = 1'b0;
        wgt        = '0;
        feat_valid = 1'b0;
        feat       = '0;
        while (rst !== 1'b0)
        begin
            @(posedge clk);
        end
        test_reset();
        test_uniform();
        test_data(1'b1, 16'd0);
        test_data(1'b0, 16'hffff);
        test_back_to_back();
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with tests still running",
                 WATCHDOG_CYCLES);
        abort_run();
    end

endmodule
